/* hdl/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // angle in units of 180/256 degree
    localparam int ANGLE_W   = 8;
    localparam int ANGLE_45  = 64;
    localparam int ANGLE_135 = 192;
    localparam int SECTOR_W  = 3;

    // filtered RAM sample address and data
    localparam int S_W    = 8;
    localparam int DATA_W = 12;

    // line and partition geometry
    localparam int LINE_SIZE      = 16;
    localparam int LINE_W         = $clog2(LINE_SIZE);
    localparam int PARTITION_SIZE = 4;
    localparam int ITR_W          = 2;

    // fixed-point accumulators, integer part is the sample address
    localparam int ACCU_W = 16;
    localparam int FRAC_W = 8;

    // per-sector stepping constants, indexed by angle[7:5]
    localparam logic [ACCU_W-1:0] SHIFT_STEP_TABLE [8] = '{
        16'h0100, 16'h0115, 16'h016a, 16'h029d,
        16'hfd63, 16'hfe96, 16'hfeeb, 16'hff00
    };
    localparam logic [ACCU_W-1:0] MAP_INIT_TABLE [8] = '{
        16'h1000, 16'h1800, 16'h2400, 16'h3000,
        16'hc000, 16'hd000, 16'he000, 16'hf000
    };
    localparam logic [ACCU_W-1:0] MAP_STEP_TABLE [8] = '{
        16'h1000, 16'h0ec8, 16'h0b50, 16'h0620,
        16'h0620, 16'h0b50, 16'h0ec8, 16'h1000
    };

    typedef enum logic {
        SCAN_X = 1'b0,
        SCAN_Y = 1'b1
    } scan_mode_e;

    typedef struct packed {
        logic [ACCU_W-1:0] shift_step;
        logic [ACCU_W-1:0] map_init;
        logic [ACCU_W-1:0] map_step;
    } angle_consts_t;

    // everything a swappable needs for one line
    typedef struct packed {
        logic [ACCU_W-1:0] accu_start;
        logic [ACCU_W-1:0] shift_step;
    } fill_cmd_t;

    typedef struct packed {
        logic                     en;
        logic signed [DATA_W-1:0] tap;
    } pe_out_t;

endpackage

`default_nettype wire

/* hdl/bp_angle_lut.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_angle_lut
    import bp_pkg::*;
(
    input  wire logic               clk,
    input  wire logic [ANGLE_W-1:0] angle,
    output angle_consts_t           consts
);

    logic [SECTOR_W-1:0] sector;

    // 22.5 degree sectors from the top bits
    assign sector = angle[ANGLE_W-1 -: SECTOR_W];

    // one cycle of latency, valid in the controller setup state
    always_ff @(posedge clk)
    begin
        consts.shift_step <= SHIFT_STEP_TABLE[sector];
        consts.map_init   <= MAP_INIT_TABLE[sector];
        consts.map_step   <= MAP_STEP_TABLE[sector];
    end

endmodule

`default_nettype wire

/* hdl/bp_swappable.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_swappable
    import bp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire fill_cmd_t                fill_cmd,
    input  wire logic                     next_itr_ack,
    input  wire logic                     swap_ack,
    input  wire logic signed [DATA_W-1:0] fr_val,
    output logic [S_W-1:0]                fr_s_val,
    output logic                          swap,
    output logic                          next_itr,
    output pe_out_t                       pe
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_FILL,
        PH_STREAM
    } phase_e;

    phase_e                   phase;
    logic [LINE_W-1:0]        cnt;
    logic                     full;
    logic                     issuing;
    logic                     streaming;
    logic [ACCU_W-1:0]        accu;
    logic [ACCU_W-1:0]        step;
    logic                     wr_vld;
    logic [LINE_W-1:0]        wr_idx;
    logic signed [DATA_W-1:0] line_buf [LINE_SIZE];

    assign issuing   = (phase == PH_FILL) && !full;
    assign streaming = (phase == PH_STREAM);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            phase <= PH_IDLE;
            cnt   <= '0;
            full  <= 1'b0;
        end
        else
        begin
            case (phase)
                PH_IDLE:
                    if (next_itr_ack)
                    begin
                        phase <= PH_FILL;
                        cnt   <= '0;
                    end
                PH_FILL:
                    if (swap_ack)
                    begin
                        phase <= PH_STREAM;
                        cnt   <= '0;
                        full  <= 1'b0;
                    end
                    else if (issuing)
                    begin
                        cnt <= cnt + 1'b1;
                        // last address goes out this cycle, data lands next cycle
                        if (cnt == LINE_W'(LINE_SIZE - 1))
                            full <= 1'b1;
                    end
                PH_STREAM:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LINE_W'(LINE_SIZE - 1))
                        phase <= PH_IDLE;
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // address ramp along the detector line
    always_ff @(posedge clk)
    begin
        if (phase == PH_IDLE && next_itr_ack)
        begin
            accu <= fill_cmd.accu_start;
            step <= fill_cmd.shift_step;
        end
        else if (issuing)
            accu <= accu + step;
    end

    // RAM read latency is one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_vld <= 1'b0;
        else
            wr_vld <= issuing;
    end

    always_ff @(posedge clk)
    begin
        wr_idx <= cnt;
        if (wr_vld)
            line_buf[wr_idx] <= fr_val;
    end

    assign fr_s_val = accu[ACCU_W-1:FRAC_W];
    assign swap     = full;
    assign next_itr = (phase == PH_IDLE);

    // taps are zero outside a burst
    assign pe = '{en: streaming, tap: streaming ? line_buf[cnt] : '0};

endmodule

`default_nettype wire

/* hdl/bp_swap_control.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_swap_control
    import bp_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire logic [ANGLE_W-1:0] hs_angle,
    input  wire logic               hs_next_angle_ack,
    output logic                    hs_next_angle,
    input  wire angle_consts_t      consts,
    input  wire logic               sw0_swap,
    input  wire logic               sw1_swap,
    input  wire logic               sw0_next_itr,
    input  wire logic               sw1_next_itr,
    input  wire pe_out_t            sw0_pe,
    input  wire pe_out_t            sw1_pe,
    output logic                    sw0_swap_ack,
    output logic                    sw1_swap_ack,
    output logic                    sw0_next_itr_ack,
    output logic                    sw1_next_itr_ack,
    output fill_cmd_t               fill_cmd,
    output pe_out_t                 pe,
    output logic                    pe_reset,
    output logic                    pe_kick,
    output scan_mode_e              pe_scan_mode
);

    typedef enum logic [2:0] {
        S_READY,
        S_SETUP,
        S_FILL,
        S_FILL_AND_SHIFT,
        S_SHIFT
    } state_e;

    state_e            state;
    state_e            next_state;
    logic              sw_sel;
    logic [ITR_W-1:0]  line_itr;
    logic              start_fill;
    scan_mode_e        scan_mode;
    logic [ACCU_W-1:0] map_accu;
    logic [ACCU_W-1:0] angle_map_step;
    logic [ACCU_W-1:0] angle_shift_step;
    logic              swa_swap;
    logic              swa_next_itr;
    logic              swb_next_itr;
    logic              swap_ack;
    logic              has_next_itr;
    logic              swb_next_itr_ack;

    // side A fills, side B streams
    assign swa_swap     = sw_sel ? sw1_swap : sw0_swap;
    assign swa_next_itr = sw_sel ? sw1_next_itr : sw0_next_itr;
    assign swb_next_itr = sw_sel ? sw0_next_itr : sw1_next_itr;

    assign swap_ack = (state == S_FILL || state == S_FILL_AND_SHIFT) &&
                      swa_swap && swb_next_itr;
    assign has_next_itr     = (line_itr != ITR_W'(PARTITION_SIZE - 1));
    assign swb_next_itr_ack = swap_ack && has_next_itr;

    assign sw0_swap_ack     = !sw_sel && swap_ack;
    assign sw1_swap_ack     = sw_sel && swap_ack;
    assign sw0_next_itr_ack = sw_sel ? swb_next_itr_ack : start_fill;
    assign sw1_next_itr_ack = sw_sel ? start_fill : swb_next_itr_ack;

    // first line takes the map start, later lines one map step further
    assign fill_cmd = '{accu_start: swap_ack ? map_accu + angle_map_step : map_accu,
                        shift_step: angle_shift_step};

    assign hs_next_angle = (state == S_READY);
    assign pe            = sw_sel ? sw0_pe : sw1_pe;
    assign pe_reset      = start_fill;
    assign pe_kick       = swap_ack;
    assign pe_scan_mode  = scan_mode;

    always_comb
    begin
        next_state = state;
        case (state)
            S_READY:
                if (hs_next_angle_ack)
                    next_state = S_SETUP;
            S_SETUP:
                if (swa_next_itr)
                    next_state = S_FILL;
            S_FILL:
                if (swap_ack)
                    next_state = has_next_itr ? S_FILL_AND_SHIFT : S_SHIFT;
            S_FILL_AND_SHIFT:
                if (swap_ack && !has_next_itr)
                    next_state = S_SHIFT;
            S_SHIFT:
                // last line done streaming
                if (swb_next_itr)
                    next_state = S_READY;
            default:
                next_state = S_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= S_READY;
            sw_sel     <= 1'b0;
            line_itr   <= '0;
            start_fill <= 1'b0;
            scan_mode  <= SCAN_X;
        end
        else
        begin
            state      <= next_state;
            start_fill <= (state == S_SETUP) && swa_next_itr;
            if (swap_ack)
                sw_sel <= !sw_sel;
            if (state == S_SETUP)
                line_itr <= '0;
            else if (swap_ack)
                line_itr <= line_itr + 1'b1;
            // held for the whole angle
            if (state == S_SETUP)
            begin
                if (hs_angle < ANGLE_W'(ANGLE_45) || hs_angle >= ANGLE_W'(ANGLE_135))
                    scan_mode <= SCAN_X;
                else
                    scan_mode <= SCAN_Y;
            end
        end
    end

    // angle constants and map accumulation
    always_ff @(posedge clk)
    begin
        if (state == S_SETUP)
        begin
            map_accu         <= consts.map_init;
            angle_map_step   <= consts.map_step;
            angle_shift_step <= consts.shift_step;
        end
        else if (swap_ack)
            map_accu <= map_accu + angle_map_step;
    end

endmodule

`default_nettype wire

/* hdl/bp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_top
    import bp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic [ANGLE_W-1:0]       hs_angle,
    input  wire logic                     hs_next_angle_ack,
    output logic                          hs_next_angle,
    input  wire logic signed [DATA_W-1:0] fr0_val,
    input  wire logic signed [DATA_W-1:0] fr1_val,
    output logic [S_W-1:0]                fr0_s_val,
    output logic [S_W-1:0]                fr1_s_val,
    output pe_out_t                       pe,
    output logic                          pe_reset,
    output logic                          pe_kick,
    output scan_mode_e                    pe_scan_mode
);

    angle_consts_t consts;
    fill_cmd_t     fill_cmd;
    pe_out_t       sw0_pe;
    pe_out_t       sw1_pe;
    logic          sw0_swap;
    logic          sw1_swap;
    logic          sw0_next_itr;
    logic          sw1_next_itr;
    logic          sw0_swap_ack;
    logic          sw1_swap_ack;
    logic          sw0_next_itr_ack;
    logic          sw1_next_itr_ack;

    bp_angle_lut angle_lut (
        .clk    (clk),
        .angle  (hs_angle),
        .consts (consts)
    );

    bp_swap_control swap_control (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .consts            (consts),
        .sw0_swap          (sw0_swap),
        .sw1_swap          (sw1_swap),
        .sw0_next_itr      (sw0_next_itr),
        .sw1_next_itr      (sw1_next_itr),
        .sw0_pe            (sw0_pe),
        .sw1_pe            (sw1_pe),
        .sw0_swap_ack      (sw0_swap_ack),
        .sw1_swap_ack      (sw1_swap_ack),
        .sw0_next_itr_ack  (sw0_next_itr_ack),
        .sw1_next_itr_ack  (sw1_next_itr_ack),
        .fill_cmd          (fill_cmd),
        .pe                (pe),
        .pe_reset          (pe_reset),
        .pe_kick           (pe_kick),
        .pe_scan_mode      (pe_scan_mode)
    );

    // ping-pong line buffers, one per RAM port
    bp_swappable sw0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_cmd     (fill_cmd),
        .next_itr_ack (sw0_next_itr_ack),
        .swap_ack     (sw0_swap_ack),
        .fr_val       (fr0_val),
        .fr_s_val     (fr0_s_val),
        .swap         (sw0_swap),
        .next_itr     (sw0_next_itr),
        .pe           (sw0_pe)
    );

    bp_swappable sw1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_cmd     (fill_cmd),
        .next_itr_ack (sw1_next_itr_ack),
        .swap_ack     (sw1_swap_ack),
        .fr_val       (fr1_val),
        .fr_s_val     (fr1_s_val),
        .swap         (sw1_swap),
        .next_itr     (sw1_next_itr),
        .pe           (sw1_pe)
    );

endmodule

`default_nettype wire

/* verif/bp_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bp_tb
    import bp_pkg::*;
();

    localparam logic [31:0] SEED = 32'd23363;
    localparam int REQ_TIMEOUT = 400;
    localparam logic [ANGLE_W-1:0] EDGE_ANGLES [8] = '{0, 63, 64, 100, 140, 191, 192, 255};

    logic                     clk;
    logic                     reset_n;
    logic [ANGLE_W-1:0]       hs_angle;
    logic                     hs_next_angle_ack;
    logic                     hs_next_angle;
    logic signed [DATA_W-1:0] fr0_val;
    logic signed [DATA_W-1:0] fr1_val;
    logic [S_W-1:0]           fr0_s_val;
    logic [S_W-1:0]           fr1_s_val;
    pe_out_t                  pe;
    logic                     pe_reset;
    logic                     pe_kick;
    scan_mode_e               pe_scan_mode;

    // filtered projection RAM contents per read port
    logic signed [DATA_W-1:0] ram0 [256];
    logic signed [DATA_W-1:0] ram1 [256];
    logic [S_W-1:0]           addr0;
    logic [S_W-1:0]           addr1;

    logic [31:0]              rng_state;
    logic signed [DATA_W-1:0] exp_taps [$];
    scan_mode_e               exp_mode;
    string                    cur_test;
    int                       errors;
    int                       pass_count;
    int                       fail_count;
    int                       cyc;
    int                       ack_cyc;
    int                       kick_count;
    int                       reset_count;
    int                       tap_count;
    int                       burst_len;
    logic                     in_burst;
    logic                     prev_kick;
    logic                     timed_out;

    bp_top i_bp_top (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .fr0_val           (fr0_val),
        .fr1_val           (fr1_val),
        .fr0_s_val         (fr0_s_val),
        .fr1_s_val         (fr1_s_val),
        .pe                (pe),
        .pe_reset          (pe_reset),
        .pe_kick           (pe_kick),
        .pe_scan_mode      (pe_scan_mode)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // one cycle read latency on both ports
    initial
    begin
        forever
        begin
            @(negedge clk);
            addr0 = fr0_s_val;
            addr1 = fr1_s_val;
            @(posedge clk);
            #1;
            fr0_val = ram0[addr0];
            fr1_val = ram1[addr1];
        end
    end

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     cur_test, what, $signed(expected), $signed(actual));
            errors++;
        end
    endtask

    // sampled mid-cycle where outputs are stable
    always @(negedge clk)
    begin
        cyc++;
        if (reset_n)
        begin
            if (hs_next_angle_ack)
                ack_cyc = cyc;
            if (pe_reset)
            begin
                reset_count++;
                compare_value("pe_reset cycle after ack", ack_cyc + 2, cyc);
            end
            if (pe_kick)
                kick_count++;
            if (pe.en)
            begin
                if (!in_burst)
                begin
                    assert (prev_kick)
                    else
                    begin
                        $display("test %s: pe_en burst started without a pe_kick", cur_test);
                        errors++;
                    end
                    burst_len = 0;
                end
                in_burst = 1'b1;
                burst_len++;
                tap_count++;
                compare_value("pe_scan_mode", exp_mode, pe_scan_mode);
                assert (exp_taps.size() > 0)
                else
                begin
                    $display("test %s: tap seen with no tap left to expect", cur_test);
                    errors++;
                end
                if (exp_taps.size() > 0)
                    compare_value("tap", exp_taps.pop_front(), pe.tap);
            end
            else
            begin
                if (in_burst)
                begin
                    compare_value("burst length", LINE_SIZE, burst_len);
                    in_burst = 1'b0;
                end
                compare_value("tap outside burst", 0, pe.tap);
            end
            prev_kick = pe_kick;
        end
    end

    // line k comes from port k mod 2
    task automatic build_expected(input logic [ANGLE_W-1:0] angle);
        logic [SECTOR_W-1:0] s;
        logic [ACCU_W-1:0]   line_start;
        logic [ACCU_W-1:0]   sum;
        logic [S_W-1:0]      addr;
        int                  k;
        int                  j;
        exp_taps.delete();
        s = angle[ANGLE_W-1 -: SECTOR_W];
        for (k = 0; k < PARTITION_SIZE; k++)
        begin
            line_start = MAP_INIT_TABLE[s] + ACCU_W'(k) * MAP_STEP_TABLE[s];
            for (j = 0; j < LINE_SIZE; j++)
            begin
                sum  = line_start + ACCU_W'(j) * SHIFT_STEP_TABLE[s];
                addr = sum[ACCU_W-1:FRAC_W];
                exp_taps.push_back((k % 2 == 0) ? ram0[addr] : ram1[addr]);
            end
        end
        exp_mode = (angle < ANGLE_45 || angle >= ANGLE_135) ? SCAN_X : SCAN_Y;
    endtask

    task automatic wait_for_request();
        int n;
        n = 0;
        @(negedge clk);
        while (!hs_next_angle && n < REQ_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!hs_next_angle)
        begin
            $display("test %s: timed out waiting for hs_next_angle", cur_test);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input int errors_before);
        if (errors == errors_before)
        begin
            pass_count++;
            $display("test %s: passed", cur_test);
        end
        else
        begin
            fail_count++;
            $display("test %s: failed", cur_test);
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        cur_test = "reset_state";
        errors_before = errors;
        @(negedge clk);
        compare_value("hs_next_angle", 1, hs_next_angle);
        compare_value("pe_en", 0, pe.en);
        compare_value("pe_kick", 0, pe_kick);
        compare_value("pe_reset", 0, pe_reset);
        report_test(errors_before);
    endtask

    task automatic run_angle(input string name, input logic [ANGLE_W-1:0] angle,
                             input int delay);
        int errors_before;
        int n;
        cur_test = name;
        errors_before = errors;
        wait_for_request();
        if (!timed_out)
        begin
            // host holds off the acknowledge
            for (n = 0; n < delay; n++)
            begin
                @(negedge clk);
                assert (hs_next_angle)
                else
                begin
                    $display("test %s: hs_next_angle dropped before the acknowledge",
                             cur_test);
                    errors++;
                end
            end
            build_expected(angle);
            kick_count  = 0;
            reset_count = 0;
            tap_count   = 0;
            @(posedge clk);
            #1;
            hs_angle          = angle;
            hs_next_angle_ack = 1'b1;
            @(posedge clk);
            #1;
            hs_next_angle_ack = 1'b0;
            wait_for_request();
        end
        if (timed_out)
            fail_count++;
        else
        begin
            compare_value("pe_kick count", PARTITION_SIZE, kick_count);
            compare_value("pe_reset count", 1, reset_count);
            compare_value("tap count", PARTITION_SIZE * LINE_SIZE, tap_count);
            report_test(errors_before);
        end
    endtask

    initial
    begin
        int                 t;
        int                 rand_delay;
        logic [ANGLE_W-1:0] rand_angle;
        reset_n           = 1'b0;
        hs_angle          = '0;
        hs_next_angle_ack = 1'b0;
        fr0_val           = '0;
        fr1_val           = '0;
        in_burst          = 1'b0;
        prev_kick         = 1'b0;
        timed_out         = 1'b0;
        cyc               = 0;
        ack_cyc           = -10;
        cur_test          = "startup";
        rng_state         = SEED;
        for (t = 0; t < 256; t++)
            ram0[t] = DATA_W'(next_random());
        for (t = 0; t < 256; t++)
            ram1[t] = DATA_W'(next_random());
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_reset_state();
        for (t = 0; t < 8; t++)
        begin
            if (!timed_out)
                run_angle($sformatf("angle_%0d", EDGE_ANGLES[t]), EDGE_ANGLES[t], 0);
        end
        for (t = 0; t < 6; t++)
        begin
            rand_angle = ANGLE_W'(next_random());
            rand_delay = next_random() % 31;
            if (!timed_out)
                run_angle($sformatf("backpressure_%0d", t), rand_angle, rand_delay);
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/bp_pkg.sv
hdl/bp_angle_lut.sv
hdl/bp_swappable.sv
hdl/bp_swap_control.sv
hdl/bp_top.sv
verif/bp_tb.sv

/* Bender.yml */
package:
  name: bp_swap_subsystem

sources:
  - target: any(hdl, verif)
    files:
      - hdl/bp_pkg.sv
      - hdl/bp_angle_lut.sv
      - hdl/bp_swappable.sv
      - hdl/bp_swap_control.sv
      - hdl/bp_top.sv
  - target: verif
    files:
      - verif/bp_tb.sv
